// File: common/xbus_pkg.sv
// Bus widths, external address map, master and port indices, address rule type
package xbus_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W   = DATA_W / 8;

  // One address map entry, end address exclusive
  typedef struct packed {
    logic [ADDR_W-1:0] idx;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] end_addr;
  } addr_rule_t;

  // Crossbar master numbering
  localparam int unsigned CORE_IDX       = 0;
  localparam int unsigned DMA_IDX        = 1;
  localparam int unsigned SYSTEM_NMASTER = 2;
  // The external master sits right after the system masters
  localparam int unsigned EXTM_IDX       = SYSTEM_NMASTER;

  // Demux port numbering
  localparam int unsigned DEMUX_INT_IDX = 0;
  localparam int unsigned DEMUX_EXT_IDX = 1;

  // External memories behind the crossbar
  localparam int unsigned EXT_NRULES = 2;
  localparam addr_rule_t [EXT_NRULES-1:0] EXT_RULES = '{
    '{idx: 32'd1, start_addr: 32'h2000_1000, end_addr: 32'h2000_2000},
    '{idx: 32'd0, start_addr: 32'h2000_0000, end_addr: 32'h2000_1000}
  };

  // Window steered to the crossbar by the demux
  localparam addr_rule_t [0:0] DEMUX_RULE = '{
    '{idx: DEMUX_EXT_IDX, start_addr: 32'h2000_0000, end_addr: 32'h2001_0000}
  };

endpackage

// File: source/addr_decoder.sv
// Address decoder mapping an address to a port index through a rule table
`timescale 1ns/1ps

module addr_decoder import xbus_pkg::*; #(
  parameter int unsigned NRULES = 1,
  parameter int unsigned NIDX   = 2,
  localparam int unsigned IW    = NIDX > 1 ? $clog2(NIDX) : 1
) (
  input  logic [ADDR_W-1:0]           addr_i,
  input  addr_rule_t [NRULES-1:0]     rules_i,
  input  logic [IW-1:0]               default_idx_i,
  output logic [IW-1:0]               idx_o
);

  logic hit;

  // First matching rule wins, so later rules cannot override it
  always_comb begin
    hit   = 1'b0;
    idx_o = default_idx_i;
    for (int i = 0; i < NRULES; i++) begin
      if (!hit && addr_i >= rules_i[i].start_addr && addr_i < rules_i[i].end_addr) begin
        hit   = 1'b1;
        idx_o = rules_i[i].idx[IW-1:0];
      end
    end
  end

endmodule

// File: xbar/xbar_arbiter.sv
// Round-robin arbiter for one crossbar slave port
`timescale 1ns/1ps

module xbar_arbiter #(
  parameter int unsigned NREQ = 3,
  localparam int unsigned IW  = NREQ > 1 ? $clog2(NREQ) : 1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic [NREQ-1:0] req_i,
  input  logic            gnt_i,
  output logic [IW-1:0]   sel_o,
  output logic            valid_o
);

  // Requester holding the highest priority this cycle
  logic [IW-1:0] ptr_q;

  // Scan downwards so the candidate closest to the pointer is kept last
  always_comb begin
    int cand;
    sel_o   = '0;
    valid_o = 1'b0;
    for (int k = NREQ - 1; k >= 0; k--) begin
      cand = (int'(ptr_q) + k) % int'(NREQ);
      if (req_i[cand]) begin
        sel_o   = IW'(cand);
        valid_o = 1'b1;
      end
    end
  end

  // Move past the winner only once its address phase is done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (gnt_i) begin
      if (sel_o == IW'(NREQ - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= sel_o + 1'b1;
      end
    end
  end

endmodule

// File: xbar/xbar_n_to_m.sv
// N-to-M OBI crossbar with per-slave round-robin and in-order response routing
`timescale 1ns/1ps

module xbar_n_to_m import xbus_pkg::*; #(
  parameter int unsigned NMASTER         = 3,
  parameter int unsigned NSLAVE          = 2,
  parameter int unsigned MAX_OUTSTANDING = 2,
  localparam int unsigned MIW    = NMASTER > 1 ? $clog2(NMASTER) : 1,
  localparam int unsigned SIW    = NSLAVE > 1 ? $clog2(NSLAVE) : 1,
  localparam int unsigned CW     = $clog2(MAX_OUTSTANDING + 1),
  localparam int unsigned SDEPTH = NMASTER * MAX_OUTSTANDING,
  localparam int unsigned SPW    = SDEPTH > 1 ? $clog2(SDEPTH) : 1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [SIW-1:0]                   default_idx_i,
  input  logic [NMASTER-1:0]               m_req_i,
  input  logic [NMASTER-1:0]               m_we_i,
  input  logic [NMASTER-1:0][BE_W-1:0]     m_be_i,
  input  logic [NMASTER-1:0][ADDR_W-1:0]   m_addr_i,
  input  logic [NMASTER-1:0][DATA_W-1:0]   m_wdata_i,
  output logic [NMASTER-1:0]               m_gnt_o,
  output logic [NMASTER-1:0]               m_rvalid_o,
  output logic [NMASTER-1:0][DATA_W-1:0]   m_rdata_o,
  output logic [NSLAVE-1:0]                s_req_o,
  output logic [NSLAVE-1:0]                s_we_o,
  output logic [NSLAVE-1:0][BE_W-1:0]      s_be_o,
  output logic [NSLAVE-1:0][ADDR_W-1:0]    s_addr_o,
  output logic [NSLAVE-1:0][DATA_W-1:0]    s_wdata_o,
  input  logic [NSLAVE-1:0]                s_gnt_i,
  input  logic [NSLAVE-1:0]                s_rvalid_i,
  input  logic [NSLAVE-1:0][DATA_W-1:0]    s_rdata_i
);

  logic [NMASTER-1:0][SIW-1:0] tgt;
  logic [NMASTER-1:0][CW-1:0]  out_cnt_q;
  logic [NMASTER-1:0][SIW-1:0] out_slv_q;
  logic [NMASTER-1:0]          req_ok;
  logic [NSLAVE-1:0][MIW-1:0]  arb_sel;
  logic [NSLAVE-1:0]           arb_valid;
  logic [NSLAVE-1:0][MIW-1:0]  rsp_head;

  // Master side
  // ------------------------------
  for (genvar i = 0; i < NMASTER; i++) begin : gen_master
    addr_decoder #(
      .NRULES(EXT_NRULES),
      .NIDX  (NSLAVE)
    ) addr_decoder_inst (
      .addr_i       (m_addr_i[i]),
      .rules_i      (EXT_RULES),
      .default_idx_i(default_idx_i),
      .idx_o        (tgt[i])
    );

    // Hold back a switch of target while responses are pending, or when full
    assign req_ok[i] = m_req_i[i] && out_cnt_q[i] != CW'(MAX_OUTSTANDING)
                       && (out_cnt_q[i] == '0 || out_slv_q[i] == tgt[i]);

    // All pending transactions of a master share one slave
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        out_cnt_q[i] <= '0;
        out_slv_q[i] <= '0;
      end else begin
        if (m_gnt_o[i]) begin
          out_slv_q[i] <= tgt[i];
        end
        if (m_gnt_o[i] && !m_rvalid_o[i]) begin
          out_cnt_q[i] <= out_cnt_q[i] + 1'b1;
        end else if (!m_gnt_o[i] && m_rvalid_o[i]) begin
          out_cnt_q[i] <= out_cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // Slave side
  // ------------------------------
  for (genvar s = 0; s < NSLAVE; s++) begin : gen_slave
    logic [NMASTER-1:0]            slv_req;
    logic [SDEPTH-1:0][MIW-1:0]    owner_q;
    logic [SPW-1:0]                wptr_q;
    logic [SPW-1:0]                rptr_q;

    always_comb begin
      for (int i = 0; i < NMASTER; i++) begin
        slv_req[i] = req_ok[i] && tgt[i] == SIW'(s);
      end
    end

    xbar_arbiter #(
      .NREQ(NMASTER)
    ) xbar_arbiter_inst (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (slv_req),
      .gnt_i  (s_gnt_i[s] && arb_valid[s]),
      .sel_o  (arb_sel[s]),
      .valid_o(arb_valid[s])
    );

    assign s_req_o[s]   = arb_valid[s];
    assign s_we_o[s]    = m_we_i[arb_sel[s]];
    assign s_be_o[s]    = m_be_i[arb_sel[s]];
    assign s_addr_o[s]  = m_addr_i[arb_sel[s]];
    assign s_wdata_o[s] = m_wdata_i[arb_sel[s]];

    // Owner of each accepted request, oldest at the read pointer
    always_ff @(posedge clk_i) begin
      if (s_req_o[s] && s_gnt_i[s]) begin
        owner_q[wptr_q] <= arb_sel[s];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wptr_q <= '0;
        rptr_q <= '0;
      end else begin
        if (s_req_o[s] && s_gnt_i[s]) begin
          wptr_q <= (wptr_q == SPW'(SDEPTH - 1)) ? '0 : wptr_q + 1'b1;
        end
        if (s_rvalid_i[s]) begin
          rptr_q <= (rptr_q == SPW'(SDEPTH - 1)) ? '0 : rptr_q + 1'b1;
        end
      end
    end

    assign rsp_head[s] = owner_q[rptr_q];
  end

  // Grant back to the winning master of each slave
  always_comb begin
    m_gnt_o = '0;
    for (int s = 0; s < NSLAVE; s++) begin
      if (arb_valid[s] && s_gnt_i[s]) begin
        m_gnt_o[arb_sel[s]] = 1'b1;
      end
    end
  end

  // Responses to the owner recorded at grant time
  always_comb begin
    m_rvalid_o = '0;
    m_rdata_o  = '0;
    for (int s = 0; s < NSLAVE; s++) begin
      if (s_rvalid_i[s]) begin
        m_rvalid_o[rsp_head[s]] = 1'b1;
        m_rdata_o[rsp_head[s]]  = s_rdata_i[s];
      end
    end
  end

endmodule

// File: xbar/demux_one_to_two.sv
// 1-to-2 OBI demultiplexer with a FIFO of outstanding sides
`timescale 1ns/1ps

module demux_one_to_two import xbus_pkg::*; #(
  parameter int unsigned MAX_OUTSTANDING = 2,
  localparam int unsigned PW = MAX_OUTSTANDING > 1 ? $clog2(MAX_OUTSTANDING) : 1,
  localparam int unsigned CW = $clog2(MAX_OUTSTANDING + 1)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              m_req_i,
  input  logic              m_we_i,
  input  logic [BE_W-1:0]   m_be_i,
  input  logic [ADDR_W-1:0] m_addr_i,
  input  logic [DATA_W-1:0] m_wdata_i,
  output logic              m_gnt_o,
  output logic              m_rvalid_o,
  output logic [DATA_W-1:0] m_rdata_o,
  output logic              int_req_o,
  output logic              int_we_o,
  output logic [BE_W-1:0]   int_be_o,
  output logic [ADDR_W-1:0] int_addr_o,
  output logic [DATA_W-1:0] int_wdata_o,
  input  logic              int_gnt_i,
  input  logic              int_rvalid_i,
  input  logic [DATA_W-1:0] int_rdata_i,
  output logic              ext_req_o,
  output logic              ext_we_o,
  output logic [BE_W-1:0]   ext_be_o,
  output logic [ADDR_W-1:0] ext_addr_o,
  output logic [DATA_W-1:0] ext_wdata_o,
  input  logic              ext_gnt_i,
  input  logic              ext_rvalid_i,
  input  logic [DATA_W-1:0] ext_rdata_i
);

  logic                       side;
  logic                       req_ok;
  logic                       head;
  logic [MAX_OUTSTANDING-1:0] side_q;
  logic [PW-1:0]              wptr_q;
  logic [PW-1:0]              rptr_q;
  logic [CW-1:0]              cnt_q;

  addr_decoder #(
    .NRULES(1),
    .NIDX  (2)
  ) addr_decoder_inst (
    .addr_i       (m_addr_i),
    .rules_i      (DEMUX_RULE),
    .default_idx_i(1'(DEMUX_INT_IDX)),
    .idx_o        (side)
  );

  assign head   = side_q[rptr_q];
  // No side switch until the other side has drained
  assign req_ok = m_req_i && cnt_q != CW'(MAX_OUTSTANDING) && (cnt_q == '0 || head == side);

  // Request fields go to both sides, only req is steered
  assign int_req_o   = req_ok && side == 1'(DEMUX_INT_IDX);
  assign ext_req_o   = req_ok && side == 1'(DEMUX_EXT_IDX);
  assign int_we_o    = m_we_i;
  assign int_be_o    = m_be_i;
  assign int_addr_o  = m_addr_i;
  assign int_wdata_o = m_wdata_i;
  assign ext_we_o    = m_we_i;
  assign ext_be_o    = m_be_i;
  assign ext_addr_o  = m_addr_i;
  assign ext_wdata_o = m_wdata_i;

  assign m_gnt_o    = req_ok && (side == 1'(DEMUX_EXT_IDX) ? ext_gnt_i : int_gnt_i);
  assign m_rvalid_o = cnt_q != '0 && (head == 1'(DEMUX_EXT_IDX) ? ext_rvalid_i : int_rvalid_i);
  assign m_rdata_o  = head == 1'(DEMUX_EXT_IDX) ? ext_rdata_i : int_rdata_i;

  always_ff @(posedge clk_i) begin
    if (m_gnt_o) begin
      side_q[wptr_q] <= side;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (m_gnt_o) begin
        wptr_q <= (wptr_q == PW'(MAX_OUTSTANDING - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (m_rvalid_o) begin
        rptr_q <= (rptr_q == PW'(MAX_OUTSTANDING - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (m_gnt_o && !m_rvalid_o) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!m_gnt_o && m_rvalid_o) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

// File: source/bus_sram.sv
// OBI word memory with byte enables and a one-cycle response
`timescale 1ns/1ps

module bus_sram import xbus_pkg::*; #(
  parameter int unsigned MEM_WORDS = 1024,
  localparam int unsigned AW   = MEM_WORDS > 1 ? $clog2(MEM_WORDS) : 1,
  localparam int unsigned OFFS = $clog2(BE_W)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic [AW-1:0]     word_idx;
  logic [DATA_W-1:0] rdata_q;
  logic              rvalid_q;

  // Always ready
  assign gnt_o    = req_i;
  // Higher address bits alias onto the same words
  assign word_idx = AW'((addr_i >> OFFS) % MEM_WORDS);

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  // One response per accepted request, reads and writes alike
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: source/ext_bus_top.sv
// External bus top level with demux, crossbar, internal and external memories
`timescale 1ns/1ps

module ext_bus_top import xbus_pkg::*; #(
  parameter int unsigned NMASTER         = 3,
  parameter int unsigned NSLAVE          = 2,
  parameter int unsigned MEM_WORDS       = 1024,
  parameter int unsigned MAX_OUTSTANDING = 2,
  localparam int unsigned SIW = NSLAVE > 1 ? $clog2(NSLAVE) : 1
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [SIW-1:0]    default_idx_i,
  // Core data port
  input  logic              core_req_i,
  input  logic              core_we_i,
  input  logic [BE_W-1:0]   core_be_i,
  input  logic [ADDR_W-1:0] core_addr_i,
  input  logic [DATA_W-1:0] core_wdata_i,
  output logic              core_gnt_o,
  output logic              core_rvalid_o,
  output logic [DATA_W-1:0] core_rdata_o,
  // DMA port
  input  logic              dma_req_i,
  input  logic              dma_we_i,
  input  logic [BE_W-1:0]   dma_be_i,
  input  logic [ADDR_W-1:0] dma_addr_i,
  input  logic [DATA_W-1:0] dma_wdata_i,
  output logic              dma_gnt_o,
  output logic              dma_rvalid_o,
  output logic [DATA_W-1:0] dma_rdata_o,
  // External master port
  input  logic              extm_req_i,
  input  logic              extm_we_i,
  input  logic [BE_W-1:0]   extm_be_i,
  input  logic [ADDR_W-1:0] extm_addr_i,
  input  logic [DATA_W-1:0] extm_wdata_i,
  output logic              extm_gnt_o,
  output logic              extm_rvalid_o,
  output logic [DATA_W-1:0] extm_rdata_o
);

  // Crossbar master side
  logic [NMASTER-1:0]             m_req;
  logic [NMASTER-1:0]             m_we;
  logic [NMASTER-1:0][BE_W-1:0]   m_be;
  logic [NMASTER-1:0][ADDR_W-1:0] m_addr;
  logic [NMASTER-1:0][DATA_W-1:0] m_wdata;
  logic [NMASTER-1:0]             m_gnt;
  logic [NMASTER-1:0]             m_rvalid;
  logic [NMASTER-1:0][DATA_W-1:0] m_rdata;

  // Crossbar slave side
  logic [NSLAVE-1:0]              s_req;
  logic [NSLAVE-1:0]              s_we;
  logic [NSLAVE-1:0][BE_W-1:0]    s_be;
  logic [NSLAVE-1:0][ADDR_W-1:0]  s_addr;
  logic [NSLAVE-1:0][DATA_W-1:0]  s_wdata;
  logic [NSLAVE-1:0]              s_gnt;
  logic [NSLAVE-1:0]              s_rvalid;
  logic [NSLAVE-1:0][DATA_W-1:0]  s_rdata;

  // Demux to internal memory
  logic              int_req;
  logic              int_we;
  logic [BE_W-1:0]   int_be;
  logic [ADDR_W-1:0] int_addr;
  logic [DATA_W-1:0] int_wdata;
  logic              int_gnt;
  logic              int_rvalid;
  logic [DATA_W-1:0] int_rdata;

  // System masters enter the crossbar directly
  assign m_req[CORE_IDX]   = core_req_i;
  assign m_we[CORE_IDX]    = core_we_i;
  assign m_be[CORE_IDX]    = core_be_i;
  assign m_addr[CORE_IDX]  = core_addr_i;
  assign m_wdata[CORE_IDX] = core_wdata_i;
  assign core_gnt_o        = m_gnt[CORE_IDX];
  assign core_rvalid_o     = m_rvalid[CORE_IDX];
  assign core_rdata_o      = m_rdata[CORE_IDX];

  assign m_req[DMA_IDX]    = dma_req_i;
  assign m_we[DMA_IDX]     = dma_we_i;
  assign m_be[DMA_IDX]     = dma_be_i;
  assign m_addr[DMA_IDX]   = dma_addr_i;
  assign m_wdata[DMA_IDX]  = dma_wdata_i;
  assign dma_gnt_o         = m_gnt[DMA_IDX];
  assign dma_rvalid_o      = m_rvalid[DMA_IDX];
  assign dma_rdata_o       = m_rdata[DMA_IDX];

  // External master splits between internal memory and crossbar
  // ------------------------------
  demux_one_to_two #(
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) demux_one_to_two_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .m_req_i     (extm_req_i),
    .m_we_i      (extm_we_i),
    .m_be_i      (extm_be_i),
    .m_addr_i    (extm_addr_i),
    .m_wdata_i   (extm_wdata_i),
    .m_gnt_o     (extm_gnt_o),
    .m_rvalid_o  (extm_rvalid_o),
    .m_rdata_o   (extm_rdata_o),
    .int_req_o   (int_req),
    .int_we_o    (int_we),
    .int_be_o    (int_be),
    .int_addr_o  (int_addr),
    .int_wdata_o (int_wdata),
    .int_gnt_i   (int_gnt),
    .int_rvalid_i(int_rvalid),
    .int_rdata_i (int_rdata),
    .ext_req_o   (m_req[EXTM_IDX]),
    .ext_we_o    (m_we[EXTM_IDX]),
    .ext_be_o    (m_be[EXTM_IDX]),
    .ext_addr_o  (m_addr[EXTM_IDX]),
    .ext_wdata_o (m_wdata[EXTM_IDX]),
    .ext_gnt_i   (m_gnt[EXTM_IDX]),
    .ext_rvalid_i(m_rvalid[EXTM_IDX]),
    .ext_rdata_i (m_rdata[EXTM_IDX])
  );

  // External crossbar
  // ------------------------------
  xbar_n_to_m #(
    .NMASTER        (NMASTER),
    .NSLAVE         (NSLAVE),
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) xbar_n_to_m_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .default_idx_i(default_idx_i),
    .m_req_i      (m_req),
    .m_we_i       (m_we),
    .m_be_i       (m_be),
    .m_addr_i     (m_addr),
    .m_wdata_i    (m_wdata),
    .m_gnt_o      (m_gnt),
    .m_rvalid_o   (m_rvalid),
    .m_rdata_o    (m_rdata),
    .s_req_o      (s_req),
    .s_we_o       (s_we),
    .s_be_o       (s_be),
    .s_addr_o     (s_addr),
    .s_wdata_o    (s_wdata),
    .s_gnt_i      (s_gnt),
    .s_rvalid_i   (s_rvalid),
    .s_rdata_i    (s_rdata)
  );

  // Memories
  // ------------------------------
  bus_sram #(
    .MEM_WORDS(MEM_WORDS)
  ) int_mem (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (int_req),
    .we_i    (int_we),
    .be_i    (int_be),
    .addr_i  (int_addr),
    .wdata_i (int_wdata),
    .gnt_o   (int_gnt),
    .rvalid_o(int_rvalid),
    .rdata_o (int_rdata)
  );

  bus_sram #(
    .MEM_WORDS(MEM_WORDS)
  ) ext_mem0 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (s_req[0]),
    .we_i    (s_we[0]),
    .be_i    (s_be[0]),
    .addr_i  (s_addr[0]),
    .wdata_i (s_wdata[0]),
    .gnt_o   (s_gnt[0]),
    .rvalid_o(s_rvalid[0]),
    .rdata_o (s_rdata[0])
  );

  bus_sram #(
    .MEM_WORDS(MEM_WORDS)
  ) ext_mem1 (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (s_req[1]),
    .we_i    (s_we[1]),
    .be_i    (s_be[1]),
    .addr_i  (s_addr[1]),
    .wdata_i (s_wdata[1]),
    .gnt_o   (s_gnt[1]),
    .rvalid_o(s_rvalid[1]),
    .rdata_o (s_rdata[1])
  );

endmodule

// File: test/ext_bus_checker.sv
// Bound assertions on the three master ports of the external bus top level
`timescale 1ns/1ps

module ext_bus_checker import xbus_pkg::*; (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              core_req_i, core_we_i, core_gnt_o, core_rvalid_o,
  input logic [BE_W-1:0]   core_be_i,
  input logic [ADDR_W-1:0] core_addr_i,
  input logic [DATA_W-1:0] core_wdata_i,
  input logic              dma_req_i, dma_we_i, dma_gnt_o, dma_rvalid_o,
  input logic [BE_W-1:0]   dma_be_i,
  input logic [ADDR_W-1:0] dma_addr_i,
  input logic [DATA_W-1:0] dma_wdata_i,
  input logic              extm_req_i, extm_we_i, extm_gnt_o, extm_rvalid_o,
  input logic [BE_W-1:0]   extm_be_i,
  input logic [ADDR_W-1:0] extm_addr_i,
  input logic [DATA_W-1:0] extm_wdata_i
);

  // Request fields frozen until the address phase completes
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_req_i && !core_gnt_o |=>
      core_req_i && $stable({core_we_i, core_be_i, core_addr_i, core_wdata_i}))
    else $error("core request changed before its grant");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dma_req_i && !dma_gnt_o |=>
      dma_req_i && $stable({dma_we_i, dma_be_i, dma_addr_i, dma_wdata_i}))
    else $error("dma request changed before its grant");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    extm_req_i && !extm_gnt_o |=>
      extm_req_i && $stable({extm_we_i, extm_be_i, extm_addr_i, extm_wdata_i}))
    else $error("external master request changed before its grant");

  // No response can leave the bus during reset
  assert property (@(posedge clk_i)
    !rst_ni |-> !(core_rvalid_o || dma_rvalid_o || extm_rvalid_o))
    else $error("rvalid high during reset");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((core_gnt_o && !core_req_i) || (dma_gnt_o && !dma_req_i) || (extm_gnt_o && !extm_req_i)))
    else $error("grant without a request");

endmodule

bind ext_bus_top ext_bus_checker ext_bus_checker_inst (.*);

// File: test/ext_bus_tb.sv
// Clock, reset, stimulus table, reference memory model and checks for the external bus
`timescale 1ns/1ps

module ext_bus_tb import xbus_pkg::*; ();

  localparam int unsigned MEM_WORDS = 1024;
  localparam int          TIMEOUT   = 50;
  localparam int          NRAND     = 12;

  typedef struct {
    int                m;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    logic              dflt;
    logic [DATA_W-1:0] exp;
  } op_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   default_idx;
  // Master ports indexed 0 core, 1 DMA and 2 external master
  logic [2:0]             bus_req, bus_we, bus_gnt, bus_rvalid;
  logic [2:0][BE_W-1:0]   bus_be;
  logic [2:0][ADDR_W-1:0] bus_addr;
  logic [2:0][DATA_W-1:0] bus_wdata, bus_rdata;
  // Mirror of int_mem, ext_mem0 and ext_mem1
  logic [DATA_W-1:0]      model_mem [3][MEM_WORDS];
  op_t                    ops [$];

  ext_bus_top #(
    .NMASTER(3), .NSLAVE(2), .MEM_WORDS(MEM_WORDS), .MAX_OUTSTANDING(2)
  ) ext_bus_top_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .default_idx_i(default_idx),
    .core_req_i(bus_req[0]), .core_we_i(bus_we[0]), .core_be_i(bus_be[0]),
    .core_addr_i(bus_addr[0]), .core_wdata_i(bus_wdata[0]), .core_gnt_o(bus_gnt[0]),
    .core_rvalid_o(bus_rvalid[0]), .core_rdata_o(bus_rdata[0]),
    .dma_req_i(bus_req[1]), .dma_we_i(bus_we[1]), .dma_be_i(bus_be[1]),
    .dma_addr_i(bus_addr[1]), .dma_wdata_i(bus_wdata[1]), .dma_gnt_o(bus_gnt[1]),
    .dma_rvalid_o(bus_rvalid[1]), .dma_rdata_o(bus_rdata[1]),
    .extm_req_i(bus_req[2]), .extm_we_i(bus_we[2]), .extm_be_i(bus_be[2]),
    .extm_addr_i(bus_addr[2]), .extm_wdata_i(bus_wdata[2]), .extm_gnt_o(bus_gnt[2]),
    .extm_rvalid_o(bus_rvalid[2]), .extm_rdata_o(bus_rdata[2])
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic check(input string what, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Memory a master reaches as 0 int_mem, 1 ext_mem0 or 2 ext_mem1
  function automatic int target_mem(input int m, input logic [ADDR_W-1:0] a, input logic d);
    if (m == 2 && (a < 32'h2000_0000 || a >= 32'h2001_0000)) return 0;
    if (a >= 32'h2000_0000 && a < 32'h2000_1000) return 1;
    if (a >= 32'h2000_1000 && a < 32'h2000_2000) return 2;
    return d ? 2 : 1;
  endfunction

  function automatic logic rival_gnt(input int m);
    if (m == 0) return bus_gnt[1];
    if (m == 1) return bus_gnt[0];
    return 1'b0;
  endfunction

  // Apply a granted transfer to the model and return the addressed word
  function automatic logic [DATA_W-1:0] model_access(input int m, input logic we,
                                                     input logic [ADDR_W-1:0] addr,
                                                     input logic [DATA_W-1:0] wdata,
                                                     input logic [BE_W-1:0] be);
    int sel;
    int idx;
    sel = target_mem(m, addr, default_idx);
    idx = int'((addr >> 2) % MEM_WORDS);
    if (we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) model_mem[sel][idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return model_mem[sel][idx];
  endfunction

  // Response due on the falling edge one cycle after the grant
  task automatic expect_response(input int m, input logic we, input logic [DATA_W-1:0] exp);
    check("rvalid one cycle after the grant", DATA_W'(bus_rvalid[m]), 32'd1);
    if (!we) check("read data against the model", bus_rdata[m], exp);
  endtask

  task automatic add_op(input int m, input logic we, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                        input logic dflt, input logic [DATA_W-1:0] exp);
    op_t op;
    op = '{m: m, we: we, addr: addr, wdata: wdata, be: be, dflt: dflt, exp: exp};
    ops.push_back(op);
  endtask

  // One OBI transfer with outputs sampled on falling edges
  task automatic run_txn(input int m, input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                         input logic dflt, output logic [DATA_W-1:0] data);
    int                waited;
    logic [DATA_W-1:0] exp;
    waited = 0;
    @(posedge clk_i);
    default_idx  <= dflt;
    bus_req[m]   <= 1'b1;
    bus_we[m]    <= we;
    bus_be[m]    <= be;
    bus_addr[m]  <= addr;
    bus_wdata[m] <= wdata;
    @(negedge clk_i);
    while (!bus_gnt[m]) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timeout at %0t ns: master %0d never got a grant", $time, m);
        $display("FAIL: see errors above");
        $fatal(1, "grant wait timed out");
      end
      @(negedge clk_i);
    end
    check("rvalid before the grant edge", DATA_W'(bus_rvalid[m]), 32'd0);
    exp = model_access(m, we, addr, wdata, be);
    @(posedge clk_i);
    bus_req[m] <= 1'b0;
    @(negedge clk_i);
    expect_response(m, we, exp);
    data = bus_rdata[m];
  endtask

  // Back-to-back random transfers to ext_mem0 with req held between them
  task automatic burst_txn(input int m, input int n);
    int                waited;
    int                rival;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    logic              pend;
    logic              pend_we;
    logic [DATA_W-1:0] pend_exp;
    pend     = 1'b0;
    pend_we  = 1'b0;
    pend_exp = '0;
    for (int t = 0; t < n; t++) begin
      we     = 1'($urandom);
      addr   = 32'h2000_0200 + (($urandom % 8) << 2);
      wdata  = $urandom;
      be     = 4'($urandom);
      waited = 0;
      rival  = 0;
      @(posedge clk_i);
      bus_req[m]   <= 1'b1;
      bus_we[m]    <= we;
      bus_be[m]    <= be;
      bus_addr[m]  <= addr;
      bus_wdata[m] <= wdata;
      @(negedge clk_i);
      // Previous grant edge was the one just passed
      if (pend) begin
        expect_response(m, pend_we, pend_exp);
        pend = 1'b0;
      end
      while (!bus_gnt[m]) begin
        if (rival_gnt(m)) rival++;
        waited++;
        if (waited > TIMEOUT) begin
          $display("Timeout at %0t ns: master %0d never got a grant", $time, m);
          $display("FAIL: see errors above");
          $fatal(1, "grant wait timed out");
        end
        @(negedge clk_i);
      end
      check("wait behind the rival master", DATA_W'(rival <= 2), 32'd1);
      pend_exp = model_access(m, we, addr, wdata, be);
      pend_we  = we;
      pend     = 1'b1;
    end
    @(posedge clk_i);
    bus_req[m] <= 1'b0;
    @(negedge clk_i);
    if (pend) expect_response(m, pend_we, pend_exp);
  endtask

  initial begin
    logic [DATA_W-1:0] rd;
    void'($urandom(56082));
    rst_ni      = 1'b0;
    default_idx = 1'b0;
    bus_req     = '0;
    bus_we      = '0;
    bus_be      = '0;
    bus_addr    = '0;
    bus_wdata   = '0;
    // master, we, addr, wdata, be, default slave, expected read data
    add_op(0, 1, 32'h2000_0010, 32'h1122_3344, 4'hF, 0, 32'h0);
    add_op(0, 0, 32'h2000_0010, 32'h0,         4'hF, 0, 32'h1122_3344);
    add_op(0, 1, 32'h2000_0010, 32'hAABB_CCDD, 4'h5, 0, 32'h0);
    add_op(0, 0, 32'h2000_0010, 32'h0,         4'hF, 0, 32'h11BB_33DD);
    add_op(0, 1, 32'h2000_1020, 32'hDEAD_BEEF, 4'hF, 0, 32'h0);
    add_op(0, 1, 32'h2000_1020, 32'h0000_5A00, 4'h2, 0, 32'h0);
    add_op(0, 0, 32'h2000_1020, 32'h0,         4'hF, 0, 32'hDEAD_5AEF);
    add_op(2, 1, 32'h2000_0040, 32'hCAFE_0001, 4'hF, 0, 32'h0);
    add_op(2, 0, 32'h2000_0040, 32'h0,         4'hF, 0, 32'hCAFE_0001);
    add_op(2, 1, 32'h1000_0040, 32'h0BAD_F00D, 4'hF, 0, 32'h0);
    add_op(2, 0, 32'h1000_0040, 32'h0,         4'hF, 0, 32'h0BAD_F00D);
    add_op(2, 0, 32'h2000_1020, 32'h0,         4'hF, 0, 32'hDEAD_5AEF);
    add_op(0, 0, 32'h2000_0040, 32'h0,         4'hF, 0, 32'hCAFE_0001);
    add_op(0, 1, 32'h3000_0080, 32'h1234_5678, 4'hF, 0, 32'h0);
    add_op(0, 0, 32'h2000_0080, 32'h0,         4'hF, 0, 32'h1234_5678);
    add_op(0, 1, 32'h3000_0084, 32'h8765_4321, 4'hF, 1, 32'h0);
    add_op(0, 0, 32'h2000_1084, 32'h0,         4'hF, 1, 32'h8765_4321);
    add_op(0, 0, 32'h3000_0084, 32'h0,         4'hF, 1, 32'h8765_4321);
    add_op(1, 1, 32'h2000_0100, 32'h0F0F_0F0F, 4'hF, 0, 32'h0);
    add_op(1, 0, 32'h2000_0100, 32'h0,         4'hF, 0, 32'h0F0F_0F0F);
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (ops[i]) begin
      run_txn(ops[i].m, ops[i].we, ops[i].addr, ops[i].wdata, ops[i].be, ops[i].dflt, rd);
      if (!ops[i].we) check("read data against the table", rd, ops[i].exp);
    end
    // Words shared by core and DMA under contention
    for (int k = 0; k < 8; k++) begin
      run_txn(0, 1'b1, 32'h2000_0200 + 32'(4 * k), $urandom, 4'hF, 1'b0, rd);
    end
    fork
      burst_txn(0, NRAND);
      burst_txn(1, NRAND);
    join
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: files.f
common/xbus_pkg.sv
source/addr_decoder.sv
xbar/xbar_arbiter.sv
xbar/xbar_n_to_m.sv
xbar/demux_one_to_two.sv
source/bus_sram.sv
source/ext_bus_top.sv
test/ext_bus_checker.sv
test/ext_bus_tb.sv

// File: Makefile
# Verilator lint, simulation and clean targets for the external bus

VERILATOR ?= verilator
TOP       ?= ext_bus_tb
FILELIST  ?= files.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The log decides the result, the grep status fails the target
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
